//--- design/spi_target_defs.svh
`ifndef SPI_TARGET_DEFS_SVH
`define SPI_TARGET_DEFS_SVH

// -----------------------------------------------
// SPI target build constants
// -----------------------------------------------

// Receive FIFO depth in bytes
// Also sets the initial credit count of the receiver
`define SPI_FIFO_DEPTH 4

// First byte shifted out on MISO in every frame
`define SPI_HEADER_BYTE 8'hA7

// Flops per pin in the input synchroniser
`define SPI_SYNC_STAGES 2

`endif

//--- design/spi_target_pkg.sv
package spi_target_pkg;

   // -----------------------------------------------
   // SPI pins as seen by the target
   // -----------------------------------------------
   // Mode 0, SCK idles low, csn active low
   typedef struct packed {
      logic sck;
      logic csn;
      logic mosi;
   } spi_pins_t;

   // -----------------------------------------------
   // Wishbone-like bus
   // -----------------------------------------------
   // Master outputs
   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      logic [7:0] dat;
   } bus_req_t;

   // Slave response, single-cycle ack
   typedef struct packed {
      logic       ack;
      logic [7:0] dat;
   } bus_rsp_t;

   // Bus master FSM states
   typedef enum logic [1:0] {
      BUS_IDLE,
      BUS_READ,
      BUS_WRITE
   } bus_state_e;

endpackage

//--- design/spi_frame_rx.sv
`timescale 1ns/1ps

`include "spi_target_defs.svh"

module spi_frame_rx (
   input  logic                      clk_i,
   input  logic                      SSEL,
   input  spi_target_pkg::spi_pins_t pins_i,
   input  logic                      credit_i,
   output logic                      push_o,
   output logic [7:0]                byte_o,
   output logic                      frame_o,
   output logic                      sck_fall_o,
   output logic                      byte_start_o,
   output logic                      overflow_o
);
   import spi_target_pkg::*;

   localparam int CNT_W = $clog2(`SPI_FIFO_DEPTH + 1);
   // Pin levels while no host drives the bus
   localparam spi_pins_t PINS_IDLE = '{sck: 1'b0, csn: 1'b1, mosi: 1'b0};

   spi_pins_t [`SPI_SYNC_STAGES-1:0] sync_q;
   spi_pins_t                        pins_s;
   logic                             sck_prev_q;
   logic                             frame_q;
   logic                             sck_rise;
   logic                             byte_done;
   logic [2:0]                       bit_cnt_q;
   logic                             started_q;
   logic [7:0]                       rx_shift_q;
   logic [CNT_W-1:0]                 credit_q;
   logic                             spend;
   logic                             push_q;
   logic                             overflow_q;

   // -----------------------------------------------
   // Pin synchroniser and edge detect
   // -----------------------------------------------
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         sync_q     <= {`SPI_SYNC_STAGES{PINS_IDLE}};
         sck_prev_q <= 1'b0;
         frame_q    <= 1'b0;
      end else begin
         sync_q     <= {sync_q[`SPI_SYNC_STAGES-2:0], pins_i};
         sck_prev_q <= pins_s.sck;
         // Frame level, one flop after the synchroniser
         frame_q    <= ~pins_s.csn;
      end
   end

   assign pins_s = sync_q[`SPI_SYNC_STAGES-1];

   // Edges only count inside a frame
   assign sck_rise   = frame_q & pins_s.sck & ~sck_prev_q;
   assign sck_fall_o = frame_q & ~pins_s.sck & sck_prev_q;

   // Eighth rise of a byte
   assign byte_done = sck_rise & (bit_cnt_q == 3'd7);
   assign spend     = byte_done & (credit_q != '0);

   // First fall after a finished byte starts the next one
   assign byte_start_o = sck_fall_o & started_q & (bit_cnt_q == 3'd0);

   // -----------------------------------------------
   // Bit counter and MOSI shift register
   // -----------------------------------------------
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         bit_cnt_q <= 3'd0;
         started_q <= 1'b0;
      end else if (!frame_q) begin
         bit_cnt_q <= 3'd0;
         started_q <= 1'b0;
      end else if (sck_rise) begin
         bit_cnt_q <= bit_cnt_q + 3'd1;
         if (byte_done)
            started_q <= 1'b1;
      end
   end

   // MSB first, sampled on rises
   always_ff @(posedge clk_i) begin
      if (sck_rise)
         rx_shift_q <= {rx_shift_q[6:0], pins_s.mosi};
   end

   // -----------------------------------------------
   // Credits towards the FIFO
   // -----------------------------------------------
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         credit_q   <= CNT_W'(`SPI_FIFO_DEPTH);
         push_q     <= 1'b0;
         overflow_q <= 1'b0;
      end else begin
         credit_q <= credit_q + CNT_W'(credit_i) - CNT_W'(spend);
         push_q   <= spend;
         // Byte with no credit is lost, flag stays until reset
         if (byte_done && credit_q == '0)
            overflow_q <= 1'b1;
      end
   end

   // Shift register holds the full byte in the push cycle
   assign push_o     = push_q;
   assign byte_o     = rx_shift_q;
   assign frame_o    = frame_q;
   assign overflow_o = overflow_q;

endmodule

//--- design/spi_byte_fifo.sv
`timescale 1ns/1ps

`include "spi_target_defs.svh"

module spi_byte_fifo (
   input  logic       clk_i,
   input  logic       SSEL,
   input  logic       push_i,
   input  logic [7:0] byte_i,
   input  logic       pop_i,
   output logic [7:0] head_o,
   output logic       valid_o,
   output logic       credit_o
);

   localparam int PTR_W = (`SPI_FIFO_DEPTH > 1) ? $clog2(`SPI_FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(`SPI_FIFO_DEPTH + 1);

   logic [7:0]       mem_q [`SPI_FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             do_pop;
   logic             credit_q;

   // Wrap at the last entry, depth need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(`SPI_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Pops on an empty FIFO are ignored
   assign do_pop = pop_i & (count_q != '0);

   // -----------------------------------------------
   // Storage
   // -----------------------------------------------
   // Producer only pushes with a credit in hand, so no full check
   always_ff @(posedge clk_i) begin
      if (push_i)
         mem_q[wr_ptr_q] <= byte_i;
   end

   // Pointers, fill level and credit return
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         credit_q <= 1'b0;
      end else begin
         if (push_i)
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (do_pop)
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         count_q  <= count_q + CNT_W'(push_i) - CNT_W'(do_pop);
         // One credit back per byte read, a cycle later
         credit_q <= do_pop;
      end
   end

   assign head_o   = mem_q[rd_ptr_q];
   assign valid_o  = (count_q != '0);
   assign credit_o = credit_q;

endmodule

//--- design/spi_bus_master.sv
`timescale 1ns/1ps

module spi_bus_master (
   input  logic                     clk_i,
   input  logic                     SSEL,
   input  logic                     frame_i,
   input  logic [7:0]               head_i,
   input  logic                     valid_i,
   output logic                     pop_o,
   input  logic                     fetch_i,
   output logic                     load_o,
   output logic [7:0]               load_data_o,
   output spi_target_pkg::bus_req_t bus_o,
   input  spi_target_pkg::bus_rsp_t bus_i
);
   import spi_target_pkg::*;

   bus_state_e state_q;
   logic [7:0] dat_q;
   logic       rd_done;
   logic       wr_done;

   // -----------------------------------------------
   // Transfer FSM
   // -----------------------------------------------
   // One outstanding transfer at a time
   // Reads win over writes so MISO data arrives before the byte boundary
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         state_q <= BUS_IDLE;
         dat_q   <= 8'h00;
      end else begin
         case (state_q)
            BUS_IDLE: begin
               if (fetch_i) begin
                  state_q <= BUS_READ;
               end else if (valid_i) begin
                  state_q <= BUS_WRITE;
                  // Head stays put until the pop
                  dat_q   <= head_i;
               end
            end
            BUS_READ: begin
               // Held until ack, even past the end of the frame
               if (bus_i.ack)
                  state_q <= BUS_IDLE;
            end
            BUS_WRITE: begin
               if (bus_i.ack)
                  state_q <= BUS_IDLE;
            end
            default: begin
               state_q <= BUS_IDLE;
            end
         endcase
      end
   end

   // Transfer ends in the ack cycle
   assign rd_done = (state_q == BUS_READ) & bus_i.ack;
   assign wr_done = (state_q == BUS_WRITE) & bus_i.ack;

   // -----------------------------------------------
   // Handshakes to the FIFO and transmitter
   // -----------------------------------------------
   // Written byte leaves the FIFO
   assign pop_o = wr_done;

   // Read data goes straight to the staging register
   assign load_o      = rd_done;
   assign load_data_o = bus_i.dat;

   // -----------------------------------------------
   // Bus outputs
   // -----------------------------------------------
   always_comb begin
      // cyc frames the SPI transaction
      bus_o.cyc = frame_i;
      // stb and we held for the whole transfer
      bus_o.stb = (state_q != BUS_IDLE);
      bus_o.we  = (state_q == BUS_WRITE);
      bus_o.dat = dat_q;
   end

endmodule

//--- design/spi_frame_tx.sv
`timescale 1ns/1ps

`include "spi_target_defs.svh"

module spi_frame_tx (
   input  logic       clk_i,
   input  logic       SSEL,
   input  logic       frame_i,
   input  logic       sck_fall_i,
   input  logic       byte_start_i,
   input  logic       load_i,
   input  logic [7:0] load_data_i,
   output logic       fetch_o,
   output logic       miso_o,
   output logic       underrun_o
);

   localparam logic [7:0] HEADER = `SPI_HEADER_BYTE;

   logic [7:0] shift_q;
   logic [7:0] staged_data_q;
   logic       staged_valid_q;
   logic       underrun_q;
   logic       load_ok;

   // Late reads after the frame are dropped
   assign load_ok = load_i & frame_i;

   // -----------------------------------------------
   // Staging register
   // -----------------------------------------------
   always_ff @(posedge clk_i) begin
      if (load_ok)
         staged_data_q <= load_data_i;
   end

   // -----------------------------------------------
   // MISO shift register
   // -----------------------------------------------
   // Header MSB sits on MISO before the first SCK edge
   always_ff @(posedge clk_i or posedge SSEL) begin
      if (SSEL) begin
         shift_q        <= HEADER;
         staged_valid_q <= 1'b0;
         underrun_q     <= 1'b0;
      end else if (!frame_i) begin
         // Idle between frames, ready for the next header
         shift_q        <= HEADER;
         staged_valid_q <= 1'b0;
      end else begin
         if (byte_start_i) begin
            // Next byte, or zeros when nothing was fetched in time
            shift_q <= staged_valid_q ? staged_data_q : 8'h00;
            if (!staged_valid_q)
               underrun_q <= 1'b1;
         end else if (sck_fall_i) begin
            // MSB first
            shift_q <= {shift_q[6:0], 1'b0};
         end

         if (load_ok)
            staged_valid_q <= 1'b1;
         else if (byte_start_i)
            staged_valid_q <= 1'b0;
      end
   end

   // Ask the master for data whenever the stage is free
   assign fetch_o = frame_i & ~staged_valid_q;

   assign miso_o     = shift_q[7];
   assign underrun_o = underrun_q;

endmodule

//--- design/spi_target_top.sv
`timescale 1ns/1ps

module spi_target_top (
   input  logic                      clk_i,
   input  logic                      SSEL,
   input  spi_target_pkg::spi_pins_t pins_i,
   output logic                      miso_o,
   output spi_target_pkg::bus_req_t  bus_o,
   input  spi_target_pkg::bus_rsp_t  bus_i,
   output logic                      overflow_o,
   output logic                      underrun_o
);

   // Receiver to FIFO
   logic       rx_push;
   logic [7:0] rx_byte;
   logic       fifo_credit;
   // FIFO to bus master
   logic [7:0] fifo_head;
   logic       fifo_valid;
   logic       fifo_pop;
   // Frame timing to bus master and transmitter
   logic       frame;
   logic       sck_fall;
   logic       byte_start;
   // Bus master to transmitter
   logic       tx_fetch;
   logic       tx_load;
   logic [7:0] tx_load_data;

   // -----------------------------------------------
   // Receive path
   // -----------------------------------------------
   spi_frame_rx spi_frame_rx_i (
      .clk_i        (clk_i),
      .SSEL         (SSEL),
      .pins_i       (pins_i),
      .credit_i     (fifo_credit),
      .push_o       (rx_push),
      .byte_o       (rx_byte),
      .frame_o      (frame),
      .sck_fall_o   (sck_fall),
      .byte_start_o (byte_start),
      .overflow_o   (overflow_o)
   );

   spi_byte_fifo spi_byte_fifo_i (
      .clk_i    (clk_i),
      .SSEL     (SSEL),
      .push_i   (rx_push),
      .byte_i   (rx_byte),
      .pop_i    (fifo_pop),
      .head_o   (fifo_head),
      .valid_o  (fifo_valid),
      .credit_o (fifo_credit)
   );

   // -----------------------------------------------
   // Bus side and transmit path
   // -----------------------------------------------
   spi_bus_master spi_bus_master_i (
      .clk_i       (clk_i),
      .SSEL        (SSEL),
      .frame_i     (frame),
      .head_i      (fifo_head),
      .valid_i     (fifo_valid),
      .pop_o       (fifo_pop),
      .fetch_i     (tx_fetch),
      .load_o      (tx_load),
      .load_data_o (tx_load_data),
      .bus_o       (bus_o),
      .bus_i       (bus_i)
   );

   spi_frame_tx spi_frame_tx_i (
      .clk_i        (clk_i),
      .SSEL         (SSEL),
      .frame_i      (frame),
      .sck_fall_i   (sck_fall),
      .byte_start_i (byte_start),
      .load_i       (tx_load),
      .load_data_i  (tx_load_data),
      .fetch_o      (tx_fetch),
      .miso_o       (miso_o),
      .underrun_o   (underrun_o)
   );

endmodule

//--- dv/tb_spi_target.sv
`timescale 1ns/1ps

`include "spi_target_defs.svh"

module tb_spi_target;
   import spi_target_pkg::*;

   // -----------------------------------------------
   // Run length and limits
   // -----------------------------------------------
   // SCK half period in clk_i cycles
   localparam int HALF_SCK    = 4;
   // One byte on the wire plus handshake slack
   localparam int BYTE_CYCLES = 70;
   localparam int MAX_BYTES   = `SPI_FIFO_DEPTH + 2;
   // About ten times the nominal run of five frames at BYTE_CYCLES per byte
   localparam int TIMEOUT_CYCLES = 20000;

   localparam logic [7:0] HEADER   = `SPI_HEADER_BYTE;
   localparam bus_req_t   REQ_IDLE = '{cyc: 1'b0, stb: 1'b0, we: 1'b0, dat: 8'h00};

   logic      clk_i;
   logic      SSEL;
   spi_pins_t pins_i;
   logic      miso_o;
   bus_req_t  bus_o;
   bus_rsp_t  bus_i = '0;
   logic      overflow_o;
   logic      underrun_o;

   int         seed      = 28;
   int         cycle_cnt = 0;
   int         read_cnt  = 0;
   int         ack_wait  = 0;
   logic       ack_armed = 1'b0;
   logic       stall     = 1'b0;
   logic       frame_chk = 1'b0;
   logic [7:0] exp_dat;
   // Bytes of the current frame, MISO seen, reads returned in frame
   logic [7:0] tx_bytes[$];
   logic [7:0] miso_bytes[$];
   logic [7:0] frame_reads[$];
   // Write data still owed by the DUT, oldest first
   logic [7:0] exp_writes[$];

   spi_target_top spi_target_top_i (
      .clk_i      (clk_i),
      .SSEL       (SSEL),
      .pins_i     (pins_i),
      .miso_o     (miso_o),
      .bus_o      (bus_o),
      .bus_i      (bus_i),
      .overflow_o (overflow_o),
      .underrun_o (underrun_o)
   );

   initial clk_i = 1'b0;
   always #50 clk_i = ~clk_i;

   // -----------------------------------------------
   // Reference model
   // -----------------------------------------------
   // Read data for the n-th bus read since reset
   function automatic logic [7:0] read_ref(input int n);
      return 8'((n * 3 + 5) % 256);
   endfunction

   // MISO byte k of a frame
   function automatic logic [7:0] miso_ref(input int k);
      if (k == 0)
         return HEADER;
      // Nothing returned in time, target sends zeros
      if (k - 1 < frame_reads.size())
         return frame_reads[k-1];
      return 8'h00;
   endfunction

   // -----------------------------------------------
   // Checks
   // -----------------------------------------------
   task automatic fail_run(input string what);
      $display("%s", what);
      $display("Result: FAILED");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_byte(input string name, input logic [7:0] act,
                             input logic [7:0] exp);
      if (act !== exp)
         fail_run($sformatf("Mismatch %s: got %h, expected %h", name, act, exp));
   endtask

   task automatic check_flag(input string name, input logic act, input logic exp);
      if (act !== exp)
         fail_run($sformatf("Mismatch %s: got %h, expected %h", name, act, exp));
   endtask

   // Control fields only, data is don't-care while idle
   task automatic check_bus_req(input string name, input bus_req_t act,
                                input bus_req_t exp);
      if ({act.cyc, act.stb, act.we} !== {exp.cyc, exp.stb, exp.we})
         fail_run($sformatf("Mismatch %s: got %h, expected %h", name, act, exp));
   endtask

   // -----------------------------------------------
   // Bus responder
   // -----------------------------------------------
   // Acks 0 to 3 cycles after stb is seen, holds off while stalled
   always @(posedge clk_i) begin
      if (SSEL) begin
         ack_armed = 1'b0;
      end else if (bus_i.ack) begin
         bus_i.ack <= 1'b0;
         ack_armed = 1'b0;
      end else if (bus_o.stb && !stall) begin
         if (!ack_armed) begin
            ack_armed = 1'b1;
            ack_wait  = $unsigned($random(seed)) % 4;
         end
         if (ack_wait == 0) begin
            bus_i.ack <= 1'b1;
            if (!bus_o.we) begin
               bus_i.dat <= read_ref(read_cnt);
               read_cnt  = read_cnt + 1;
            end
         end else begin
            ack_wait = ack_wait - 1;
         end
      end
   end

   // Transfer completes in a cycle with stb and ack both high
   always @(negedge clk_i) begin
      if (!SSEL) begin
         if (frame_chk && bus_o.stb)
            check_flag("bus_o.cyc", bus_o.cyc, 1'b1);
         if (bus_o.stb && bus_i.ack) begin
            if (bus_o.we) begin
               if (exp_writes.size() == 0)
                  fail_run($sformatf("Unexpected bus write of data %h", bus_o.dat));
               exp_dat = exp_writes.pop_front();
               check_byte("bus_o.dat", bus_o.dat, exp_dat);
            end else if (frame_chk) begin
               // Only reads inside the frame reach MISO
               frame_reads.push_back(bus_i.dat);
            end
         end
      end
   end

   // Watchdog
   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
         fail_run($sformatf("Timeout after %0d clock cycles", cycle_cnt));
   end

   // -----------------------------------------------
   // SPI host
   // -----------------------------------------------
   // Mode 0, MOSI changes with the fall, MISO sampled just before the rise
   task automatic send_frame();
      logic [7:0] rx;
      int         n_bits;
      n_bits = tx_bytes.size() * 8;
      frame_reads.delete();
      miso_bytes.delete();
      @(posedge clk_i);
      pins_i.csn  <= 1'b0;
      pins_i.mosi <= tx_bytes[0][7];
      for (int i = 0; i < n_bits; i++) begin
         repeat (HALF_SCK - 1) @(posedge clk_i);
         @(negedge clk_i);
         rx = {rx[6:0], miso_o};
         @(posedge clk_i);
         pins_i.sck <= 1'b1;
         frame_chk = 1'b1;
         if (i % 8 == 7)
            miso_bytes.push_back(rx);
         repeat (HALF_SCK) @(posedge clk_i);
         pins_i.sck  <= 1'b0;
         pins_i.mosi <= (i + 1 < n_bits) ? tx_bytes[(i + 1) / 8][7 - (i + 1) % 8] : 1'b0;
      end
      repeat (HALF_SCK) @(posedge clk_i);
      frame_chk = 1'b0;
      pins_i.csn <= 1'b1;
   endtask

   // One frame, then MISO check and drain of the bus writes
   task automatic run_frame(input int n_bytes, input int n_written, input logic hold_ack);
      tx_bytes.delete();
      for (int b = 0; b < n_bytes; b++) begin
         tx_bytes.push_back(8'($random(seed)));
         // Bytes past the credits are lost
         if (b < n_written)
            exp_writes.push_back(tx_bytes[b]);
      end
      stall <= hold_ack;
      send_frame();
      for (int k = 0; k < miso_bytes.size(); k++)
         check_byte($sformatf("miso_o byte %0d", k), miso_bytes[k], miso_ref(k));
      // Frame drops before ack resumes
      repeat (HALF_SCK) @(posedge clk_i);
      stall <= 1'b0;
      while (exp_writes.size() != 0)
         @(posedge clk_i);
      // Quiet gap, any stray write shows up here
      repeat (BYTE_CYCLES / 2) @(posedge clk_i);
      @(negedge clk_i);
      check_bus_req("bus_o", bus_o, REQ_IDLE);
   endtask

   // -----------------------------------------------
   // Test sequence
   // -----------------------------------------------
   initial begin
      SSEL   = 1'b1;
      pins_i = '{sck: 1'b0, csn: 1'b1, mosi: 1'b0};
      repeat (3) @(posedge clk_i);
      SSEL <= 1'b0;
      @(negedge clk_i);
      check_bus_req("bus_o", bus_o, REQ_IDLE);
      check_flag("overflow_o", overflow_o, 1'b0);
      check_flag("underrun_o", underrun_o, 1'b0);
      check_flag("miso_o", miso_o, HEADER[7]);

      // Normal traffic, bus keeps up
      run_frame(3, 3, 1'b0);
      run_frame(`SPI_FIFO_DEPTH, `SPI_FIFO_DEPTH, 1'b0);
      run_frame(5, 5, 1'b0);
      check_flag("overflow_o", overflow_o, 1'b0);
      check_flag("underrun_o", underrun_o, 1'b0);

      // Ack held off for the whole frame
      run_frame(MAX_BYTES, `SPI_FIFO_DEPTH, 1'b1);
      check_flag("overflow_o", overflow_o, 1'b1);
      check_flag("underrun_o", underrun_o, 1'b1);

      // Recovery after the stall
      run_frame(4, 4, 1'b0);

      $display("Result: PASSED");
      $finish;
   end

endmodule

//--- src.f
+incdir+design
design/spi_target_pkg.sv
design/spi_frame_rx.sv
design/spi_byte_fifo.sv
design/spi_bus_master.sv
design/spi_frame_tx.sv
design/spi_target_top.sv
dv/tb_spi_target.sv

//--- Bender.yml
package:
  name: spi_target

export_include_dirs:
  - design

sources:
  # RTL
  - include_dirs:
      - design
    files:
      - design/spi_target_pkg.sv
      - design/spi_frame_rx.sv
      - design/spi_byte_fifo.sv
      - design/spi_bus_master.sv
      - design/spi_frame_tx.sv
      - design/spi_target_top.sv
  # Testbench
  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_spi_target.sv
